/* hw/lsu_pkg.sv */
/* sizes, vector types, access-function encoding and the RV32 opcode and
   funct3 constants shared by the load/store unit */
package lsu_pkg;

    // datapath widths
    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int ROB_IDX_WIDTH  = 5;

    // on-chip data array, sized like the core's data cache
    localparam int DC_SIZE        = 1024;
    localparam int DC_DEPTH       = DC_SIZE / 4;
    localparam int DC_IDX_WIDTH   = $clog2(DC_DEPTH);
    localparam int BYTE_LANES     = DATA_WIDTH / 8;

    localparam int LSU_FUNC_WIDTH = 4;
    localparam int OPCODE_WIDTH   = 7;
    localparam int FUNCT3_WIDTH   = 3;

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [ROB_IDX_WIDTH-1:0] tag_t;
    typedef logic [DC_IDX_WIDTH-1:0]  dc_idx_t;
    typedef logic [BYTE_LANES-1:0]    byte_en_t;

    // loads first, then stores
    typedef enum logic [LSU_FUNC_WIDTH-1:0] {
        LSU_LB  = 4'd0,
        LSU_LH  = 4'd1,
        LSU_LW  = 4'd2,
        LSU_LBU = 4'd3,
        LSU_LHU = 4'd4,
        LSU_SB  = 4'd5,
        LSU_SH  = 4'd6,
        LSU_SW  = 4'd7
    } lsu_func_t;

    // major opcodes, insn[6:0]
    localparam logic [OPCODE_WIDTH-1:0] OPC_LOAD  = 7'b0000011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_STORE = 7'b0100011;

    // funct3 for loads and stores, insn[14:12]
    localparam logic [FUNCT3_WIDTH-1:0] F3_B  = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] F3_H  = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] F3_W  = 3'b010;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BU = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] F3_HU = 3'b101;

endpackage

/* hw/lsu_decode.sv */
/* request handshake, immediate extraction, address generation and the
   decode pipeline register */
`timescale 1ns/1ps

module lsu_decode import lsu_pkg::*; (
    input  logic      clk,
    input  logic      i_rst,

    input  logic      i_req,
    input  data_t     i_insn,
    input  data_t     i_src_a,
    input  data_t     i_src_b,
    input  tag_t      i_tag,
    output logic      o_ack,

    output logic      o_valid,
    output lsu_func_t o_func,
    output tag_t      o_tag,
    output addr_t     o_addr,
    output data_t     o_wdata
);

    logic [OPCODE_WIDTH-1:0] opcode;
    logic [FUNCT3_WIDTH-1:0] funct3;
    logic                    is_load;
    logic                    is_store;
    logic                    ack_q;
    logic                    accept;
    logic                    func_legal;
    lsu_func_t               func;
    data_t                   imm;
    addr_t                   eff_addr;

    assign opcode   = i_insn[6:0];
    assign funct3   = i_insn[14:12];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    // a new request is taken only once the previous ack has been low a full cycle
    assign accept = i_req && !o_ack && !ack_q;

    // S-type splits the immediate around rd, I-type keeps it in one piece
    always_comb begin
        if (is_store) begin
            imm = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
        end else begin
            imm = {{20{i_insn[31]}}, i_insn[31:20]};
        end
    end

    assign eff_addr = i_src_a + imm;

    always_comb begin
        func       = LSU_LB;
        func_legal = 1'b0;
        if (is_load) begin
            func_legal = 1'b1;
            case (funct3)
                F3_B:    func = LSU_LB;
                F3_H:    func = LSU_LH;
                F3_W:    func = LSU_LW;
                F3_BU:   func = LSU_LBU;
                F3_HU:   func = LSU_LHU;
                default: func_legal = 1'b0;
            endcase
        end else if (is_store) begin
            func_legal = 1'b1;
            case (funct3)
                F3_B:    func = LSU_SB;
                F3_H:    func = LSU_SH;
                F3_W:    func = LSU_SW;
                default: func_legal = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ack   <= 1'b0;
            ack_q   <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            ack_q   <= o_ack;
            // anything else is acked and dropped
            o_valid <= accept && func_legal;
            if (accept) begin
                o_ack <= 1'b1;
            end else if (!i_req) begin
                o_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_func  <= func;
            o_tag   <= i_tag;
            o_addr  <= eff_addr;
            o_wdata <= i_src_b;
        end
    end

    // four-phase rules seen from both sides of the port
    ack_after_req: assert property (@(posedge clk) disable iff (i_rst)
        (!i_req && !o_ack) |=> !o_ack);
    insn_held: assert property (@(posedge clk) disable iff (i_rst)
        (i_req && o_ack) |-> $stable(i_insn));

endmodule

/* hw/lsu_dcache_access.sv */
/* data array access stage: byte-lane store writes and registered word
   reads, forwarding the operation to the result stage */
`timescale 1ns/1ps

module lsu_dcache_access import lsu_pkg::*; (
    input  logic      clk,
    input  logic      i_rst,

    input  logic      i_valid,
    input  lsu_func_t i_func,
    input  tag_t      i_tag,
    input  addr_t     i_addr,
    input  data_t     i_wdata,

    output logic      o_valid,
    output lsu_func_t o_func,
    output tag_t      o_tag,
    output addr_t     o_addr,
    output data_t     o_rdata
);

    data_t    mem [DC_DEPTH];
    dc_idx_t  idx;
    byte_en_t byte_en;
    data_t    wr_data;
    logic     is_store;

    // address wraps on the array size, offset bits pick lanes only
    assign idx = i_addr[DC_IDX_WIDTH+1:2];

    assign is_store = (i_func == LSU_SB) || (i_func == LSU_SH) || (i_func == LSU_SW);

    always_comb begin
        case (i_func)
            LSU_SB: begin
                byte_en = byte_en_t'(4'b0001 << i_addr[1:0]);
                wr_data = {4{i_wdata[7:0]}};
            end
            LSU_SH: begin
                byte_en = i_addr[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{i_wdata[15:0]}};
            end
            LSU_SW: begin
                byte_en = 4'b1111;
                wr_data = i_wdata;
            end
            default: begin
                byte_en = 4'b0000;
                wr_data = i_wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_valid && is_store) begin
            for (int i = 0; i < BYTE_LANES; i++) begin
                if (byte_en[i]) begin
                    mem[idx][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // read sees the array before this edge's write
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_rdata <= mem[idx];
            o_func  <= i_func;
            o_tag   <= i_tag;
            o_addr  <= i_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // decode must never hand over a store that touches no lane
    store_has_lanes: assert property (@(posedge clk) disable iff (i_rst)
        (i_valid && is_store) |-> (byte_en != '0));

endmodule

/* hw/lsu_load_align.sv */
/* load alignment: byte/half select, sign or zero extension and the
   common data bus output register */
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*; (
    input  logic      clk,
    input  logic      i_rst,

    input  logic      i_valid,
    input  lsu_func_t i_func,
    input  tag_t      i_tag,
    input  addr_t     i_addr,
    input  data_t     i_rdata,

    output logic      o_cdb_en,
    output tag_t      o_cdb_tag,
    output addr_t     o_cdb_addr,
    output data_t     o_cdb_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    data_t       load_data;

    assign byte_sel = i_rdata[{i_addr[1:0], 3'b000} +: 8];
    assign half_sel = i_addr[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb begin
        case (i_func)
            LSU_LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
            LSU_LBU: load_data = {24'b0, byte_sel};
            LSU_LH:  load_data = {{16{half_sel[15]}}, half_sel};
            LSU_LHU: load_data = {16'b0, half_sel};
            LSU_LW:  load_data = i_rdata;
            // stores report no data
            default: load_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_cdb_tag  <= i_tag;
            o_cdb_addr <= i_addr;
            o_cdb_data <= load_data;
        end
    end

    // the handshake spaces operations, so broadcasts never go back to back
    cdb_single_pulse: assert property (@(posedge clk) disable iff (i_rst)
        o_cdb_en |=> !o_cdb_en);

endmodule

/* hw/lsu_top.sv */
/* load/store unit top level: decode, data array access and load
   alignment stages */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic  clk,
    input  logic  i_rst,

    // four-phase request
    input  logic  i_req,
    input  data_t i_insn,
    input  data_t i_src_a,
    input  data_t i_src_b,
    input  tag_t  i_tag,
    output logic  o_ack,

    // common data bus
    output logic  o_cdb_en,
    output tag_t  o_cdb_tag,
    output addr_t o_cdb_addr,
    output data_t o_cdb_data
);

    logic      d_valid;
    lsu_func_t d_func;
    tag_t      d_tag;
    addr_t     d_addr;
    data_t     d_wdata;

    logic      x_valid;
    lsu_func_t x_func;
    tag_t      x_tag;
    addr_t     x_addr;
    data_t     x_rdata;

    lsu_decode lsu_decode_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_req(i_req),
        .i_insn(i_insn),
        .i_src_a(i_src_a),
        .i_src_b(i_src_b),
        .i_tag(i_tag),
        .o_ack(o_ack),
        .o_valid(d_valid),
        .o_func(d_func),
        .o_tag(d_tag),
        .o_addr(d_addr),
        .o_wdata(d_wdata)
    );

    lsu_dcache_access lsu_dcache_access_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_valid(d_valid),
        .i_func(d_func),
        .i_tag(d_tag),
        .i_addr(d_addr),
        .i_wdata(d_wdata),
        .o_valid(x_valid),
        .o_func(x_func),
        .o_tag(x_tag),
        .o_addr(x_addr),
        .o_rdata(x_rdata)
    );

    lsu_load_align lsu_load_align_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_valid(x_valid),
        .i_func(x_func),
        .i_tag(x_tag),
        .i_addr(x_addr),
        .i_rdata(x_rdata),
        .o_cdb_en(o_cdb_en),
        .o_cdb_tag(o_cdb_tag),
        .o_cdb_addr(o_cdb_addr),
        .o_cdb_data(o_cdb_data)
    );

endmodule

/* verif/lsu_checker.sv */
/* checker: handshake and reset checks, byte-addressed reference memory,
   expected CDB queue with latency, and the cycle limit */
`timescale 1ns/1ps

module lsu_checker import lsu_pkg::*; (
    input logic  clk,
    input logic  i_rst,
    input logic  i_req,
    input data_t i_insn,
    input data_t i_src_a,
    input data_t i_src_b,
    input tag_t  i_tag,
    input logic  o_ack,
    input logic  o_cdb_en,
    input tag_t  o_cdb_tag,
    input addr_t o_cdb_addr,
    input data_t o_cdb_data
);

    localparam int CYCLE_LIMIT = 4000;

    logic [7:0] model [DC_SIZE];
    tag_t       exp_tag [$];
    addr_t      exp_addr [$];
    data_t      exp_data [$];
    int         exp_cycle [$];
    int         cycle = 0;
    int         err_count = 0;
    int         pending = 0;
    logic       timed_out = 1'b0;
    logic       ack_prev = 1'b0;
    logic       req_prev = 1'b0;
    logic       seen_req = 1'b0;

    // reference for one operation; returns 1 when a CDB entry is expected
    function automatic logic predict_op(input data_t insn, input data_t src_a,
                                        input data_t src_b, output addr_t addr,
                                        output data_t data);
        logic [6:0]  opc;
        logic [2:0]  f3;
        data_t       imm;
        int          off;
        int          lane;
        int          hl;
        logic [7:0]  b;
        logic [15:0] h;
        logic        ok;
        opc  = insn[6:0];
        f3   = insn[14:12];
        ok   = 1'b0;
        data = '0;
        if (opc == OPC_STORE) begin
            imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
        end else begin
            imm = {{20{insn[31]}}, insn[31:20]};
        end
        addr = src_a + imm;
        off  = int'(addr & addr_t'(DC_SIZE - 4));
        lane = int'(addr[1:0]);
        hl   = addr[1] ? 2 : 0;
        if (opc == OPC_STORE) begin
            ok = (f3 == F3_B) || (f3 == F3_H) || (f3 == F3_W);
            if (f3 == F3_B) begin
                model[off + lane] = src_b[7:0];
            end else if (f3 == F3_H) begin
                model[off + hl]     = src_b[7:0];
                model[off + hl + 1] = src_b[15:8];
            end else if (f3 == F3_W) begin
                for (int k = 0; k < 4; k++) begin
                    model[off + k] = src_b[k*8 +: 8];
                end
            end
        end else if (opc == OPC_LOAD) begin
            b  = model[off + lane];
            h  = {model[off + hl + 1], model[off + hl]};
            ok = 1'b1;
            case (f3)
                F3_B:    data = {{24{b[7]}}, b};
                F3_BU:   data = {24'b0, b};
                F3_H:    data = {{16{h[15]}}, h};
                F3_HU:   data = {16'b0, h};
                F3_W:    data = {model[off + 3], model[off + 2], model[off + 1], model[off]};
                default: ok = 1'b0;
            endcase
        end
        return ok;
    endfunction

    always @(posedge clk) begin
        addr_t a;
        data_t d;
        if (i_rst) begin
            ack_prev = 1'b0;
            req_prev = 1'b0;
        end else begin
            if (!seen_req) begin
                if (o_ack !== 1'b0) begin
                    $display("** Error o_ack expected %h got %h after reset", 1'b0, o_ack);
                    err_count++;
                end
                if (o_cdb_en !== 1'b0) begin
                    $display("** Error o_cdb_en expected %h got %h after reset",
                             1'b0, o_cdb_en);
                    err_count++;
                end
            end
            if (o_ack && !ack_prev && !req_prev) begin
                $display("handshake: ack rose while the request was low");
                err_count++;
            end
            if (!o_ack && ack_prev && req_prev) begin
                $display("handshake: ack fell while the request was still high");
                err_count++;
            end
            if (o_cdb_en) begin
                if (exp_tag.size() == 0) begin
                    $display("CDB broadcast with no pending operation at cycle %0d", cycle);
                    err_count++;
                end else begin
                    if (o_cdb_tag !== exp_tag[0]) begin
                        $display("** Error o_cdb_tag expected %h got %h", exp_tag[0], o_cdb_tag);
                        err_count++;
                    end
                    if (o_cdb_addr !== exp_addr[0]) begin
                        $display("** Error o_cdb_addr expected %h got %h",
                                 exp_addr[0], o_cdb_addr);
                        err_count++;
                    end
                    if (o_cdb_data !== exp_data[0]) begin
                        $display("** Error o_cdb_data expected %h got %h",
                                 exp_data[0], o_cdb_data);
                        err_count++;
                    end
                    if (cycle != exp_cycle[0]) begin
                        $display("CDB entry came at cycle %0d, expected at cycle %0d",
                                 cycle, exp_cycle[0]);
                        err_count++;
                    end
                    void'(exp_tag.pop_front());
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                    void'(exp_cycle.pop_front());
                end
            end else if (exp_cycle.size() != 0 && cycle >= exp_cycle[0]) begin
                $display("missing CDB entry for tag %h expected at cycle %0d",
                         exp_tag[0], exp_cycle[0]);
                err_count++;
                void'(exp_tag.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_cycle.pop_front());
            end
            // acceptance edge, broadcast is due three edges later
            if (i_req && !o_ack && !ack_prev) begin
                if (predict_op(i_insn, i_src_a, i_src_b, a, d)) begin
                    exp_tag.push_back(i_tag);
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                    exp_cycle.push_back(cycle + 3);
                end
            end
            seen_req = seen_req || i_req;
            ack_prev = o_ack;
            req_prev = i_req;
        end
        pending = exp_tag.size();
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            timed_out = 1'b1;
        end
    end

endmodule

/* verif/lsu_tb.sv */
/* testbench top: clock, reset, DUT instance, four-phase request driver
   and the directed and random test sequence */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    logic  clk;
    logic  i_rst;
    logic  i_req;
    data_t i_insn;
    data_t i_src_a;
    data_t i_src_b;
    tag_t  i_tag;
    logic  o_ack;
    logic  o_cdb_en;
    tag_t  o_cdb_tag;
    addr_t o_cdb_addr;
    data_t o_cdb_data;

    integer seed;
    tag_t   next_tag;
    int     err_mark;
    int     tests_passed;
    int     tests_failed;

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    lsu_top u_dut (
        .clk(clk),
        .i_rst(i_rst),
        .i_req(i_req),
        .i_insn(i_insn),
        .i_src_a(i_src_a),
        .i_src_b(i_src_b),
        .i_tag(i_tag),
        .o_ack(o_ack),
        .o_cdb_en(o_cdb_en),
        .o_cdb_tag(o_cdb_tag),
        .o_cdb_addr(o_cdb_addr),
        .o_cdb_data(o_cdb_data)
    );

    lsu_checker u_checker (
        .clk(clk),
        .i_rst(i_rst),
        .i_req(i_req),
        .i_insn(i_insn),
        .i_src_a(i_src_a),
        .i_src_b(i_src_b),
        .i_tag(i_tag),
        .o_ack(o_ack),
        .o_cdb_en(o_cdb_en),
        .o_cdb_tag(o_cdb_tag),
        .o_cdb_addr(o_cdb_addr),
        .o_cdb_data(o_cdb_data)
    );

    // I-type load, rs1 = x1, rd = x3
    function automatic data_t load_insn(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd3, OPC_LOAD};
    endfunction

    // S-type store, rs1 = x1, rs2 = x2
    function automatic data_t store_insn(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic int random_hold();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    task automatic run_op(input data_t insn, input data_t a, input data_t b, input int hold);
        @(posedge clk);
        i_req   <= 1'b1;
        i_insn  <= insn;
        i_src_a <= a;
        i_src_b <= b;
        i_tag   <= next_tag;
        do @(posedge clk); while (!o_ack);
        repeat (hold) @(posedge clk);
        i_req <= 1'b0;
        do @(posedge clk); while (o_ack);
        next_tag = next_tag + 1'b1;
    endtask

    // waits for all expected broadcasts, then reports this test's errors
    task automatic end_test(input string name);
        int errs;
        do @(negedge clk); while (u_checker.pending != 0);
        repeat (4) @(negedge clk);
        errs = u_checker.err_count - err_mark;
        err_mark = u_checker.err_count;
        if (errs == 0) begin
            tests_passed++;
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        wait (u_checker.timed_out);
        $display("run stopped: cycle limit reached before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [2:0] load_f3 [5];
        logic [2:0] store_f3 [3];
        data_t      target;
        data_t      base;
        int         imm;
        int         lane;

        load_f3  = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
        store_f3 = '{F3_B, F3_H, F3_W};
        seed         = 32'h16e4;
        next_tag     = '0;
        err_mark     = 0;
        tests_passed = 0;
        tests_failed = 0;
        i_rst   = 1'b1;
        i_req   = 1'b0;
        i_insn  = '0;
        i_src_a = '0;
        i_src_b = '0;
        i_tag   = '0;
        repeat (2) @(posedge clk);
        i_rst <= 1'b0;

        repeat (3) @(posedge clk);
        end_test("reset_state");

        // negative immediate on the load reaches the same word
        run_op(store_insn(F3_W, 12'h010), 32'h0000_0200, 32'hdead_beef, random_hold());
        run_op(load_insn(F3_W, 12'hff0), 32'h0000_0220, '0, random_hold());
        end_test("word_round_trip");

        run_op(store_insn(F3_W, 12'h000), 32'h0000_0300, 32'h0, 0);
        for (lane = 0; lane < 4; lane++) begin
            run_op(store_insn(F3_B, 12'(lane)), 32'h0000_0300,
                   32'h0000_0070 + data_t'(lane * 8'h11 + 8'h0f), random_hold());
        end
        for (lane = 0; lane < 4; lane++) begin
            run_op(load_insn(F3_B, 12'(lane)), 32'h0000_0300, '0, random_hold());
            run_op(load_insn(F3_BU, 12'(lane)), 32'h0000_0300, '0, random_hold());
        end
        run_op(store_insn(F3_H, 12'h004), 32'h0000_0300, 32'h1234_8123, 1);
        run_op(store_insn(F3_H, 12'h006), 32'h0000_0300, 32'hffff_7f45, 2);
        for (lane = 0; lane < 4; lane += 2) begin
            run_op(load_insn(F3_H, 12'(4 + lane)), 32'h0000_0300, '0, random_hold());
            run_op(load_insn(F3_HU, 12'(4 + lane)), 32'h0000_0300, '0, random_hold());
        end
        run_op(load_insn(F3_W, 12'h004), 32'h0000_0300, '0, 0);
        end_test("sub_word_access");

        // long holds, an addi and a load with a reserved funct3
        run_op(store_insn(F3_W, 12'h000), 32'h0000_0380, 32'h0bad_f00d, 12);
        run_op(32'h0050_0093, 32'h0000_0380, '0, 9);
        run_op(load_insn(3'b011, 12'h000), 32'h0000_0380, '0, 3);
        run_op(load_insn(F3_W, 12'h000), 32'h0000_0380, '0, 15);
        end_test("handshake");

        for (lane = 0; lane < 16; lane++) begin
            run_op(store_insn(F3_W, 12'(lane * 4)), 32'h0000_0100, $random(seed), 0);
        end
        for (int i = 0; i < 200; i++) begin
            target = 32'h0000_0100 + data_t'($unsigned($random(seed)) % 64);
            imm    = int'($unsigned($random(seed)) % 128) - 64;
            // high bits beyond the array size must wrap away
            base   = target - data_t'(imm) + (data_t'($random(seed)) << 10);
            next_tag = tag_t'($random(seed));
            if ($random(seed) & 1) begin
                run_op(store_insn(store_f3[$unsigned($random(seed)) % 3], 12'(imm)),
                       base, $random(seed), random_hold());
            end else begin
                run_op(load_insn(load_f3[$unsigned($random(seed)) % 5], 12'(imm)),
                       base, '0, random_hold());
            end
        end
        end_test("random_mix");

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, u_checker.err_count);
        if (tests_failed == 0 && u_checker.err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/lsu_dcache_access.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= lsu_tb
RTL_TOP    ?= lsu_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
